/* project.f */
+incdir+verilog
verilog/eval_pkg.sv
verilog/latency_sm.sv
verilog/evaluate_killer.sv
verilog/evaluate_material.sv
verilog/eval_combine.sv
verilog/board_eval.sv
tb/board_eval_tb.sv

/* run.sh */
#!/bin/sh
# Builds the board_eval testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module board_eval_tb -f project.f -o board_eval_sim

./obj_dir/board_eval_sim | tee sim.log

if grep -q "tests failed" sim.log
then
   echo "Simulation FAILED, see sim.log"
   exit 1
fi
echo "Simulation finished, see sim.log"

/* tb/board_eval_tb.sv */
// Boards B to D are the start position minus 1 to 3 black pieces picked by an LFSR.
// Expected scores come from a piece count model plus the killer bonus rule.
`timescale 1ns/1ns
`include "eval_cfg.svh"

module board_eval_tb;
   import eval_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int DRIVE_DELAY  = 2;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_ROWS     = 16;
   localparam int ROW_CYCLES   = 40;
   localparam int MAX_WAIT     = 20;
   localparam int BONUS0       = 40;
   localparam int BONUS1       = 25;
   localparam int LATENCY      = `TERM_LATENCY + 1;   // Terms, then the combiner.

   typedef enum logic [1:0] {OP_UPDATE, OP_CLEAR, OP_EVAL} op_t;
   typedef enum logic [1:0] {NO_BONUS, USE_BONUS0, USE_BONUS1} bonus_t;

   logic        clk;
   logic        arst_n;
   logic        board_valid;
   board_t      board;
   logic        clear_eval;
   logic        white_to_move;
   ply_t        killer_ply;
   board_t      killer_board;
   logic        killer_update;
   logic        killer_clear;
   score_t      killer_bonus0;
   score_t      killer_bonus1;
   score_t      eval_mg;
   score_t      eval_eg;
   logic        eval_valid;

   board_t      boards [4];
   op_t         row_op [NUM_ROWS];
   ply_t        row_ply [NUM_ROWS];
   logic [1:0]  row_board [NUM_ROWS];
   logic        row_wtm [NUM_ROWS];
   bonus_t      row_bonus [NUM_ROWS];
   int          row_count;
   logic [31:0] lfsr_state;
   int          errors;
   int          pass_count;
   int          fail_count;

   board_eval i_board_eval
   (
      .clk           (clk),
      .arst_n        (arst_n),
      .board_valid   (board_valid),
      .board         (board),
      .clear_eval    (clear_eval),
      .white_to_move (white_to_move),
      .killer_ply    (killer_ply),
      .killer_board  (killer_board),
      .killer_update (killer_update),
      .killer_clear  (killer_clear),
      .killer_bonus0 (killer_bonus0),
      .killer_bonus1 (killer_bonus1),
      .eval_mg       (eval_mg),
      .eval_eg       (eval_eg),
      .eval_valid    (eval_valid)
   );

   ////////////////////////////////////////////////////////////
   // Boards, random bits and the reference model
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1.
   endfunction

   task automatic random_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         value      = (value << 1) | int'(lfsr_state[0]);
      end
   endtask

   function automatic piece_t square_of(input board_t b, input logic [5:0] idx);
      logic [63:0][3:0] grid;
      grid = b;
      return grid[idx];
   endfunction

   // Clears count black pieces on ranks 7 and 8 but never the king.
   task automatic remove_black(inout board_t b, input int count);
      logic [63:0][3:0] grid;
      logic [5:0]       idx;
      int               pick;
      grid = b;
      while (count > 0)
      begin
         random_bits(4, pick);
         idx = 6'(48 + pick);
         if (grid[idx][3] && grid[idx][2:0] != 3'd6)
         begin
            grid[idx] = 4'd0;
            count--;
         end
      end
      b = grid;
   endtask

   // White minus black piece count per type times its value.
   function automatic int material(input board_t b, input logic eg);
      int     count [8];
      piece_t sq;
      count = '{default: 0};
      for (int i = 0; i < 64; i++)
      begin
         sq = square_of(b, 6'(i));
         if (sq[2:0] != 3'd0)
            count[sq[2:0]] += sq[3] ? -1 : 1;
      end
      if (eg)
         return count[1] * `PAWN_EG + count[2] * `KNIGHT_EG + count[3] * `BISHOP_EG +
                count[4] * `ROOK_EG + count[5] * `QUEEN_EG;
      else
         return count[1] * `PAWN_MG + count[2] * `KNIGHT_MG + count[3] * `BISHOP_MG +
                count[4] * `ROOK_MG + count[5] * `QUEEN_MG;
   endfunction

   function automatic int killer_bonus(input bonus_t code, input logic wtm);
      int bonus;
      case (code)
         USE_BONUS0: bonus = BONUS0;
         USE_BONUS1: bonus = BONUS1;
         default:    bonus = 0;
      endcase
      return wtm ? -bonus : bonus;   // Score is from White's side.
   endfunction

   ////////////////////////////////////////////////////////////
   // Checks and row drivers
   ////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic signed [31:0] got,
                              input logic signed [31:0] expected);
      if (got !== expected)
      begin
         $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
         errors++;
      end
   endtask

   task automatic end_test(input string what);
      if (errors == 0)
      begin
         pass_count++;
         $display("PASS  %s", what);
      end
      else
      begin
         fail_count++;
         $display("FAIL  %s", what);
      end
      errors = 0;
   endtask

   task automatic next_cycle(input int n);
      repeat (n) @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic add_row(input op_t op, input int ply, input int idx, input logic wtm,
                          input bonus_t bonus);
      row_op[4'(row_count)]    = op;
      row_ply[4'(row_count)]   = ply_t'(ply);
      row_board[4'(row_count)] = 2'(idx);
      row_wtm[4'(row_count)]   = wtm;
      row_bonus[4'(row_count)] = bonus;
      row_count++;
   endtask

   task automatic pulse_killer(input logic [3:0] r, input logic update);
      killer_ply   = row_ply[r];
      killer_board = boards[row_board[r]];
      next_cycle(2);                       // Ply is registered twice.
      killer_update = update;
      killer_clear  = !update;
      next_cycle(1);
      killer_update = 1'b0;
      killer_clear  = 1'b0;
      next_cycle(4);                       // Keep clear of the next request.
   endtask

   task automatic evaluate_row(input logic [3:0] r);
      int cycles;
      int exp_mg;
      int exp_eg;
      exp_mg = material(boards[row_board[r]], 1'b0) + killer_bonus(row_bonus[r], row_wtm[r]);
      exp_eg = material(boards[row_board[r]], 1'b1) + killer_bonus(row_bonus[r], row_wtm[r]);
      board         = boards[row_board[r]];
      white_to_move = row_wtm[r];
      killer_ply    = row_ply[r];
      next_cycle(3);
      board_valid = 1'b1;
      next_cycle(1);                       // Cycle 0.
      cycles = 0;
      while (!eval_valid && cycles < MAX_WAIT)
      begin
         next_cycle(1);
         cycles++;
      end
      if (!eval_valid)
      begin
         $display("Error at %0t ns: eval_valid never arrived for row %0d", $time, r);
         errors++;
      end
      else
      begin
         check_value("eval_valid latency", cycles, LATENCY);
         check_value("eval_mg", eval_mg, exp_mg);
         check_value("eval_eg", eval_eg, exp_eg);
         next_cycle(1);                    // No clear yet, so the result stays.
         check_value("eval_valid before clear_eval", eval_valid, 1);
      end
      clear_eval = 1'b1;
      next_cycle(1);
      check_value("eval_valid after clear_eval", eval_valid, 0);
      clear_eval  = 1'b0;
      board_valid = 1'b0;
      next_cycle(2);
   endtask

   task automatic run_row(input logic [3:0] r);
      case (row_op[r])
         OP_UPDATE: pulse_killer(r, 1'b1);
         OP_CLEAR:  pulse_killer(r, 1'b0);
         default:   evaluate_row(r);
      endcase
      end_test($sformatf("row %0d %s ply %0d board %0d wtm %0d", r, row_op[r].name(),
                         row_ply[r], row_board[r], row_wtm[r]));
   endtask

   ////////////////////////////////////////////////////////////
   // Clock, watchdog and main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      #(RESET_CYCLES * CLK_PERIOD + NUM_ROWS * ROW_CYCLES * CLK_PERIOD);
      $display("Timeout: the test rows did not finish in time");
      $display("tests failed");
      $finish;
   end

   initial
   begin
      arst_n        = 1'b0;
      board_valid   = 1'b0;
      board         = '0;
      clear_eval    = 1'b0;
      white_to_move = 1'b0;
      killer_ply    = '0;
      killer_board  = '0;
      killer_update = 1'b0;
      killer_clear  = 1'b0;
      killer_bonus0 = score_t'(BONUS0);
      killer_bonus1 = score_t'(BONUS1);
      errors        = 0;
      pass_count    = 0;
      fail_count    = 0;
      row_count     = 0;
      lfsr_state    = 32'h34237133;

      // Start position from rank 8 down to rank 1.
      boards[0] = {32'hCABEDBAC, 32'h99999999, 128'h0, 32'h11111111, 32'h42365324};
      for (int i = 1; i < 4; i++)
      begin
         boards[2'(i)] = boards[0];
         remove_black(boards[2'(i)], i);
      end

      add_row(OP_EVAL,   0, 0, 1'b0, NO_BONUS);
      add_row(OP_EVAL,   0, 1, 1'b0, NO_BONUS);
      add_row(OP_EVAL,   0, 2, 1'b1, NO_BONUS);
      add_row(OP_EVAL,   0, 3, 1'b0, NO_BONUS);
      add_row(OP_UPDATE, 3, 1, 1'b0, NO_BONUS);
      add_row(OP_EVAL,   3, 1, 1'b1, USE_BONUS0);
      add_row(OP_EVAL,   3, 1, 1'b0, USE_BONUS0);
      add_row(OP_UPDATE, 3, 2, 1'b0, NO_BONUS);  // B moves to slot 1.
      add_row(OP_EVAL,   3, 1, 1'b0, USE_BONUS1);
      add_row(OP_EVAL,   3, 2, 1'b1, USE_BONUS0);
      add_row(OP_EVAL,   3, 2, 1'b0, USE_BONUS0);
      add_row(OP_EVAL,   3, 3, 1'b0, NO_BONUS);
      add_row(OP_EVAL,   5, 1, 1'b0, NO_BONUS);
      add_row(OP_CLEAR,  0, 0, 1'b0, NO_BONUS);
      add_row(OP_EVAL,   3, 2, 1'b0, NO_BONUS);
      add_row(OP_EVAL,   3, 1, 1'b1, NO_BONUS);

      next_cycle(RESET_CYCLES);
      arst_n = 1'b1;
      check_value("eval_valid after reset", eval_valid, 0);
      end_test("reset");

      for (int r = 0; r < NUM_ROWS; r++)
         run_row(4'(r));

      $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

/* verilog/board_eval.sv */
// One evaluation in flight. Hold board, white_to_move and killer_ply from the
// board_valid edge until eval_valid, then pulse clear_eval.
`timescale 1ns/1ns

module board_eval
(
   input  logic             clk,
   input  logic             arst_n,
   input  logic             board_valid,
   input  eval_pkg::board_t board,
   input  logic             clear_eval,
   input  logic             white_to_move,
   input  eval_pkg::ply_t   killer_ply,
   input  eval_pkg::board_t killer_board,
   input  logic             killer_update,
   input  logic             killer_clear,
   input  eval_pkg::score_t killer_bonus0,
   input  eval_pkg::score_t killer_bonus1,
   output eval_pkg::score_t eval_mg,
   output eval_pkg::score_t eval_eg,
   output logic             eval_valid
);
   import eval_pkg::*;

   score_t killer_mg;
   score_t killer_eg;
   logic   killer_valid;
   score_t material_mg;
   score_t material_eg;
   logic   material_valid;

   evaluate_killer i_evaluate_killer
   (
      .clk           (clk),
      .arst_n        (arst_n),
      .board_valid   (board_valid),
      .board         (board),
      .clear_eval    (clear_eval),
      .white_to_move (white_to_move),
      .killer_ply    (killer_ply),
      .killer_board  (killer_board),
      .killer_update (killer_update),
      .killer_clear  (killer_clear),
      .killer_bonus0 (killer_bonus0),
      .killer_bonus1 (killer_bonus1),
      .term_mg       (killer_mg),
      .term_eg       (killer_eg),
      .term_valid    (killer_valid)
   );

   evaluate_material i_evaluate_material
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .board_valid (board_valid),
      .board       (board),
      .clear_eval  (clear_eval),
      .term_mg     (material_mg),
      .term_eg     (material_eg),
      .term_valid  (material_valid)
   );

   eval_combine i_eval_combine
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .clear_eval     (clear_eval),
      .killer_mg      (killer_mg),
      .killer_eg      (killer_eg),
      .killer_valid   (killer_valid),
      .material_mg    (material_mg),
      .material_eg    (material_eg),
      .material_valid (material_valid),
      .eval_mg        (eval_mg),
      .eval_eg        (eval_eg),
      .eval_valid     (eval_valid)
   );

endmodule

/* verilog/eval_cfg.svh */
// Sizes, latencies and piece values in centipawns. Kings score 0.
// MAX_DEPTH_LOG2 must be log2 of MAX_DEPTH.
`ifndef EVAL_CFG_SVH
`define EVAL_CFG_SVH

`define BOARD_WIDTH    256   // 64 squares of 4 bits.
`define MAX_DEPTH      16    // Plies with killer slots.
`define MAX_DEPTH_LOG2 4
`define EVAL_WIDTH     16    // Signed score.
`define TERM_LATENCY   4     // Cycles from board_valid edge to term valid.

// Middlegame and endgame piece values.
`define PAWN_MG        82
`define PAWN_EG        94
`define KNIGHT_MG      337
`define KNIGHT_EG      281
`define BISHOP_MG      365
`define BISHOP_EG      297
`define ROOK_MG        477
`define ROOK_EG        512
`define QUEEN_MG       1025
`define QUEEN_EG       936

`endif

/* verilog/eval_combine.sv */
// Terms must stay stable while their valids are high. The sum wraps
// at EVAL_WIDTH.
`timescale 1ns/1ns

module eval_combine
(
   input  logic             clk,
   input  logic             arst_n,
   input  logic             clear_eval,
   input  eval_pkg::score_t killer_mg,
   input  eval_pkg::score_t killer_eg,
   input  logic             killer_valid,
   input  eval_pkg::score_t material_mg,
   input  eval_pkg::score_t material_eg,
   input  logic             material_valid,
   output eval_pkg::score_t eval_mg,
   output eval_pkg::score_t eval_eg,
   output logic             eval_valid
);

   logic both_valid;

   assign both_valid = killer_valid && material_valid;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         eval_valid <= 1'b0;
      else if (clear_eval)
         eval_valid <= 1'b0;   // Clear wins over a late term valid.
      else if (both_valid)
         eval_valid <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (both_valid)
      begin
         eval_mg <= killer_mg + material_mg;
         eval_eg <= killer_eg + material_eg;
      end
   end

endmodule

/* verilog/eval_pkg.sv */
// Types shared by the evaluators. Widths come from eval_cfg.svh.
`include "eval_cfg.svh"

package eval_pkg;

   typedef logic [`BOARD_WIDTH-1:0] board_t;          // 64 squares, square 0 in bits 3:0.
   typedef logic [`MAX_DEPTH_LOG2-1:0] ply_t;
   typedef logic signed [`EVAL_WIDTH-1:0] score_t;    // Positive favours White.
   typedef logic [3:0] piece_t;                       // Bit 3 black, bits 2:0 type.

   // Result valid generator states.
   typedef enum logic [1:0]
   {
      IDLE,
      COUNT,
      HOLD
   } latency_state_t;

endpackage

/* verilog/evaluate_killer.sv */
// killer_ply must be stable 2 cycles before a killer_update edge, and no update
// edge may fall within 4 cycles of a board_valid edge.
`timescale 1ns/1ns
`include "eval_cfg.svh"

module evaluate_killer
(
   input  logic             clk,
   input  logic             arst_n,
   input  logic             board_valid,
   input  eval_pkg::board_t board,
   input  logic             clear_eval,
   input  logic             white_to_move,
   input  eval_pkg::ply_t   killer_ply,
   input  eval_pkg::board_t killer_board,
   input  logic             killer_update,
   input  logic             killer_clear,
   input  eval_pkg::score_t killer_bonus0,
   input  eval_pkg::score_t killer_bonus1,
   output eval_pkg::score_t term_mg,
   output eval_pkg::score_t term_eg,
   output logic             term_valid
);
   import eval_pkg::*;

   board_t                slot0_mem [`MAX_DEPTH];   // Newest killer per ply.
   board_t                slot1_mem [`MAX_DEPTH];
   logic [`MAX_DEPTH-1:0] slot0_valid;
   logic [`MAX_DEPTH-1:0] slot1_valid;
   logic                  killer_update_r;
   logic                  killer_clear_r;
   logic                  update_edge;
   logic                  clear_edge;
   ply_t                  ply_r0;
   ply_t                  ply_r1;
   board_t                slot0_q;
   board_t                slot1_q;
   logic                  slot0_valid_q;
   logic                  slot1_valid_q;
   logic                  match0;
   logic                  match1;
   score_t                bonus_sel;

   assign update_edge = killer_update && !killer_update_r;
   assign clear_edge  = killer_clear && !killer_clear_r;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         killer_update_r <= 1'b0;
         killer_clear_r  <= 1'b0;
         slot0_valid     <= '0;
         slot1_valid     <= '0;
      end
      else
      begin
         killer_update_r <= killer_update;
         killer_clear_r  <= killer_clear;
         if (clear_edge)
         begin
            slot0_valid <= '0;
            slot1_valid <= '0;
         end
         if (update_edge)
         begin
            slot0_valid[ply_r1] <= 1'b1;
            slot1_valid[ply_r1] <= slot0_valid[ply_r1];   // Shift down.
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Table storage and compare pipeline
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      ply_r0 <= killer_ply;
      ply_r1 <= ply_r0;
      if (update_edge)
      begin
         slot0_mem[ply_r1] <= killer_board;
         slot1_mem[ply_r1] <= slot0_mem[ply_r1];
      end
      slot0_q       <= slot0_mem[ply_r1];
      slot1_q       <= slot1_mem[ply_r1];
      slot0_valid_q <= slot0_valid[ply_r1];
      slot1_valid_q <= slot1_valid[ply_r1];
      match0        <= slot0_valid_q && (board == slot0_q);
      match1        <= slot1_valid_q && (board == slot1_q);
      if (!term_valid)   // Freeze the result while it is offered.
      begin
         term_mg <= white_to_move ? -bonus_sel : bonus_sel;
         term_eg <= white_to_move ? -bonus_sel : bonus_sel;
      end
   end

   always_comb
   begin
      if (match0)
         bonus_sel = killer_bonus0;   // Slot 0 wins.
      else if (match1)
         bonus_sel = killer_bonus1;
      else
         bonus_sel = '0;
   end

   latency_sm
   #(
      .LATENCY_COUNT (`TERM_LATENCY)
   )
   i_latency_sm
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .eval_valid  (term_valid)
   );

endmodule

/* verilog/evaluate_material.sv */
// Board must be held from the board_valid edge until term_valid falls.
// Kings and empty squares score 0. Sums wrap at EVAL_WIDTH.
`timescale 1ns/1ns
`include "eval_cfg.svh"

module evaluate_material
(
   input  logic             clk,
   input  logic             arst_n,
   input  logic             board_valid,
   input  eval_pkg::board_t board,
   input  logic             clear_eval,
   output eval_pkg::score_t term_mg,
   output eval_pkg::score_t term_eg,
   output logic             term_valid
);
   import eval_pkg::*;

   localparam int SQUARES = `BOARD_WIDTH / 4;

   score_t sq_mg [SQUARES];        // Stage 1, one value per square.
   score_t sq_eg [SQUARES];
   score_t s1_mg [SQUARES / 4];
   score_t s1_eg [SQUARES / 4];
   score_t s2_mg [SQUARES / 16];
   score_t s2_eg [SQUARES / 16];

   function automatic score_t piece_value(input piece_t sq, input logic eg);
      score_t val;
      case (sq[2:0])
         3'd1:    val = eg ? score_t'(`PAWN_EG)   : score_t'(`PAWN_MG);
         3'd2:    val = eg ? score_t'(`KNIGHT_EG) : score_t'(`KNIGHT_MG);
         3'd3:    val = eg ? score_t'(`BISHOP_EG) : score_t'(`BISHOP_MG);
         3'd4:    val = eg ? score_t'(`ROOK_EG)   : score_t'(`ROOK_MG);
         3'd5:    val = eg ? score_t'(`QUEEN_EG)  : score_t'(`QUEEN_MG);
         default: val = '0;   // Empty, king and unused codes.
      endcase
      return sq[3] ? -val : val;
   endfunction

   ////////////////////////////////////////////////////////////
   // Square mapping and 4-to-1 adder tree
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < SQUARES; i++)
      begin
         sq_mg[i] <= piece_value(board[4*i +: 4], 1'b0);
         sq_eg[i] <= piece_value(board[4*i +: 4], 1'b1);
      end
      for (int j = 0; j < SQUARES / 4; j++)
      begin
         s1_mg[j] <= sq_mg[4*j] + sq_mg[4*j+1] + sq_mg[4*j+2] + sq_mg[4*j+3];
         s1_eg[j] <= sq_eg[4*j] + sq_eg[4*j+1] + sq_eg[4*j+2] + sq_eg[4*j+3];
      end
      for (int k = 0; k < SQUARES / 16; k++)
      begin
         s2_mg[k] <= s1_mg[4*k] + s1_mg[4*k+1] + s1_mg[4*k+2] + s1_mg[4*k+3];
         s2_eg[k] <= s1_eg[4*k] + s1_eg[4*k+1] + s1_eg[4*k+2] + s1_eg[4*k+3];
      end
      term_mg <= s2_mg[0] + s2_mg[1] + s2_mg[2] + s2_mg[3];   // Ready after 4 edges.
      term_eg <= s2_eg[0] + s2_eg[1] + s2_eg[2] + s2_eg[3];
   end

   latency_sm
   #(
      .LATENCY_COUNT (`TERM_LATENCY)
   )
   i_latency_sm
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .eval_valid  (term_valid)
   );

endmodule

/* verilog/latency_sm.sv */
// LATENCY_COUNT must be at least 1. A new board_valid edge is ignored
// until clear_eval has returned the machine to idle.
`timescale 1ns/1ns

module latency_sm
#(
   parameter int LATENCY_COUNT = 4
)
(
   input  logic clk,
   input  logic arst_n,
   input  logic board_valid,
   input  logic clear_eval,
   output logic eval_valid
);
   import eval_pkg::*;

   localparam int CNT_W = $clog2(LATENCY_COUNT + 1);

   latency_state_t   state;
   logic [CNT_W-1:0] count;
   logic             board_valid_r;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state         <= IDLE;
         count         <= '0;
         board_valid_r <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         case (state)
            IDLE:
            begin
               if (board_valid && !board_valid_r)
               begin
                  state <= COUNT;
                  count <= CNT_W'(1);   // Edge cycle counts as the first.
               end
            end
            COUNT:
            begin
               if (count == CNT_W'(LATENCY_COUNT))
                  state <= HOLD;
               else
                  count <= count + CNT_W'(1);
            end
            HOLD:
            begin
               if (clear_eval)
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign eval_valid = (state == HOLD);

endmodule
